//--- files.f
+incdir+include
hdl/csi_pkg.sv
hdl/ctrl_pkg.sv
hdl/lane_capture.sv
hdl/lane_slice.sv
hdl/pixel_merger.sv
hdl/board_ctrl.sv
hdl/csi_frame_top.sv
dv/tb_csi_frame_top.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the CSI receive testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f files.f \
	--top-module tb_csi_frame_top -o tb_csi_frame_top > build.log 2>&1 \
	|| { cat build.log; echo "Build error"; exit 1; }

./obj_dir/tb_csi_frame_top > sim.log 2>&1 \
	|| { cat sim.log; echo "Simulation ended abnormally"; exit 1; }

cat sim.log
grep -q "Test failed" sim.log && { echo "Result: FAIL"; exit 1; }
echo "Result: PASS"

//--- include/tb_vectors.svh
`ifndef TB_VECTORS_SVH
`define TB_VECTORS_SVH

	// Columns: lane polarity, lane bytes {lane3, lane2, lane1, lane0}, expected pixel word
	typedef struct packed {
		logic [3:0]  pol;
		logic [31:0] lanes;
		logic [31:0] expected;
	} vector_t;

	localparam int NUM_VECTORS = 8;

	localparam vector_t VECTORS [NUM_VECTORS] = '{
		// Reset polarity, lanes 0 and 1 inverted
		'{4'b0011, 32'h4433_2211, 32'h4433_DDEE},
		'{4'b0000, 32'h4433_2211, 32'h4433_2211},
		'{4'b1111, 32'h00FF_55AA, 32'hFF00_AA55},
		'{4'b0101, 32'h1234_5678, 32'h12CB_5687},
		'{4'b1010, 32'hDEAD_BEEF, 32'h21AD_41EF},
		// Only the top lane swapped
		'{4'b1000, 32'hA5A5_A5A5, 32'h5AA5_A5A5},
		'{4'b0110, 32'h0F0F_0F0F, 32'h0FF0_F00F},
		'{4'b0011, 32'h0102_0304, 32'h0102_FCFB}
	};

`endif

//--- dv/tb_csi_frame_top.sv
module tb_csi_frame_top import csi_pkg::*, ctrl_pkg::*; ();

	timeunit 1ns;
	timeprecision 1ps;

	localparam int LANE_FIFO_DEPTH = 8;
	localparam int PIX_CREDITS = 4;
	localparam logic [NUM_LANES-1:0] LANE_POL_RESET = 4'b0011;
	// Cycle budget for any single wait
	localparam int WAIT_LIMIT = 200;

	`include "tb_vectors.svh"

	logic        w_csi_rx_clk;
	logic        w_sys_rstn;
	lane_bus_t   lanes_i;
	logic        vsync_i;
	reg_wr_t     reg_wr_i;
	pixel_beat_t pix_o;
	logic        credit_return_i;
	logic        overflow_o;
	logic        led_o;
	logic        pwm_o;
	// Beats seen on pix_o in arrival order
	pixel_beat_t rx_q[$];
	// Words received but not yet credited back
	int          owed;
	logic        hold_credits;
	logic [31:0] lcg_state;
	int          errors;
	int          tests_run;

	csi_frame_top #(
		.LANE_FIFO_DEPTH (LANE_FIFO_DEPTH),
		.PIX_CREDITS     (PIX_CREDITS),
		.LANE_POL_RESET  (LANE_POL_RESET)
	) UUT (.*);

	initial begin
		w_csi_rx_clk = 1'b0;
		forever #20 w_csi_rx_clk = ~w_csi_rx_clk;
	end

	//////////////////////////////////////////////////////////////////////
	// Consumer side that collects words and hands credits back
	//////////////////////////////////////////////////////////////////////

	always @(posedge w_csi_rx_clk) begin
		if (w_sys_rstn && pix_o.valid) begin
			rx_q.push_back(pix_o);
			owed = owed + 1;
		end
		// One credit per cycle and none while a test withholds them
		if (!hold_credits && owed > 0) begin
			credit_return_i <= 1'b1;
			owed = owed - 1;
		end else begin
			credit_return_i <= 1'b0;
		end
	end

	function automatic logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	// Lane i lands in byte i and is inverted where its polarity bit is set
	function automatic pixel_word_t expect_word(logic [NUM_LANES-1:0] pol,
		logic [31:0] lanes);
		pixel_word_t w;
		for (int i = 0; i < NUM_LANES; i++) begin
			w[i*8 +: 8] = pol[i] ? ~lanes[i*8 +: 8] : lanes[i*8 +: 8];
		end
		return w;
	endfunction

	task automatic check_value(string name, logic [31:0] got, logic [31:0] exp);
		assert (got == exp) else begin
			$display("MISMATCH at %0d ns: %s got 0x%h expected 0x%h", $time, name, got, exp);
			errors++;
		end
	endtask

	task automatic report_failure(string what);
		$display("ERROR at %0d ns: %s", $time, what);
		errors++;
	endtask

	task automatic write_reg(logic [7:0] code, logic [31:0] value);
		@(posedge w_csi_rx_clk);
		reg_wr_i <= '{index: REG_INDEX_CTRL, cmd: code, data: value, valid: 1'b1};
		@(posedge w_csi_rx_clk);
		reg_wr_i.valid <= 1'b0;
		// Setting must be in place before the next lane data
		repeat (2) @(posedge w_csi_rx_clk);
	endtask

	task automatic send_beat(logic [31:0] lanes);
		@(posedge w_csi_rx_clk);
		lanes_i <= '{data: lanes, valid: 1'b1};
	endtask

	task automatic end_beats();
		@(posedge w_csi_rx_clk);
		lanes_i.valid <= 1'b0;
	endtask

	task automatic pulse_vsync();
		@(posedge w_csi_rx_clk);
		vsync_i <= 1'b1;
		repeat (4) @(posedge w_csi_rx_clk);
		vsync_i <= 1'b0;
		repeat (4) @(posedge w_csi_rx_clk);
	endtask

	task automatic wait_words(int n);
		int cycles = 0;
		while (rx_q.size() < n && cycles < WAIT_LIMIT) begin
			@(posedge w_csi_rx_clk);
			cycles++;
		end
		assert (rx_q.size() >= n) else begin
			report_failure($sformatf("timed out waiting for %0d words, %0d arrived",
				n, rx_q.size()));
		end
	endtask

	// Oldest received beat against the expected word and frame flag
	task automatic take_word(pixel_word_t exp, logic exp_sof);
		pixel_beat_t b;
		assert (rx_q.size() > 0) else begin
			report_failure("an expected pixel word never arrived");
		end
		if (rx_q.size() > 0) begin
			b = rx_q.pop_front();
			check_value("pix_o.word", b.word, exp);
			check_value("pix_o.sof", 32'(b.sof), 32'(exp_sof));
		end
	endtask

	task automatic finish_test(string name, int start_errors);
		tests_run++;
		if (errors == start_errors) begin
			$display("[%0d ns] %s: ok", $time, name);
		end else begin
			$display("[%0d ns] %s: %0d errors", $time, name, errors - start_errors);
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// Test sequence
	//////////////////////////////////////////////////////////////////////

	initial begin
		int base;
		int cycles;
		int high_cycles;
		logic [31:0] lanes;
		logic [NUM_LANES-1:0] cur_pol;
		pixel_word_t exp_q[$];
		logic [NUM_LANES-1:0] pols [3] = '{4'b0011, 4'b1100, 4'b1001};
		duty_t duties [3] = '{8'd0, 8'd37, 8'd255};
		w_sys_rstn = 1'b0;
		lanes_i = '0;
		vsync_i = 1'b0;
		reg_wr_i = '0;
		credit_return_i = 1'b0;
		hold_credits = 1'b0;
		owed = 0;
		lcg_state = 32'd65;
		errors = 0;
		tests_run = 0;
		repeat (16) @(posedge w_csi_rx_clk);
		w_sys_rstn <= 1'b1;

		base = errors;
		@(posedge w_csi_rx_clk);
		check_value("pix_o.valid", 32'(pix_o.valid), 32'd0);
		check_value("overflow_o", 32'(overflow_o), 32'd0);
		check_value("led_o", 32'(led_o), 32'd0);
		check_value("pwm_o", 32'(pwm_o), 32'd0);
		finish_test("reset_state", base);

		// Row 0 runs on the reset polarity and later rows write their own
		base = errors;
		cur_pol = LANE_POL_RESET;
		for (int r = 0; r < NUM_VECTORS; r++) begin
			if (VECTORS[r].pol != cur_pol) begin
				write_reg(CMD_LANE_POL, 32'(VECTORS[r].pol));
				cur_pol = VECTORS[r].pol;
			end
			send_beat(VECTORS[r].lanes);
			end_beats();
			wait_words(1);
			take_word(VECTORS[r].expected, 1'b0);
		end
		finish_test("vector_table", base);

		// Back-to-back random beats per polarity
		base = errors;
		for (int p = 0; p < 3; p++) begin
			write_reg(CMD_LANE_POL, 32'(pols[p]));
			for (int n = 0; n < 6; n++) begin
				lanes = lcg_next();
				exp_q.push_back(expect_word(pols[p], lanes));
				send_beat(lanes);
			end
			end_beats();
			wait_words(6);
			while (exp_q.size() > 0) begin
				take_word(exp_q.pop_front(), 1'b0);
			end
		end
		finish_test("random_lanes", base);

		base = errors;
		for (int n = 0; n < 7; n++) begin
			pulse_vsync();
		end
		check_value("led_o", 32'(led_o), 32'd0);
		pulse_vsync();
		cycles = 0;
		while (!led_o && cycles < WAIT_LIMIT) begin
			@(posedge w_csi_rx_clk);
			cycles++;
		end
		assert (led_o) else begin
			report_failure("led_o stayed low after the eighth vsync rising edge");
		end
		finish_test("frame_led", base);

		// Tag follows the vsync fall and never the rise
		// Beat 0 is the first word since the last fall of the LED pulses
		base = errors;
		@(posedge w_csi_rx_clk);
		vsync_i <= 1'b1;
		repeat (4) @(posedge w_csi_rx_clk);
		for (int n = 0; n < 2; n++) begin
			lanes = lcg_next();
			exp_q.push_back(expect_word(pols[2], lanes));
			send_beat(lanes);
		end
		end_beats();
		vsync_i <= 1'b0;
		repeat (4) @(posedge w_csi_rx_clk);
		for (int n = 0; n < 3; n++) begin
			lanes = lcg_next();
			exp_q.push_back(expect_word(pols[2], lanes));
			send_beat(lanes);
		end
		end_beats();
		wait_words(5);
		for (int n = 0; n < 5; n++) begin
			take_word(exp_q.pop_front(), n == 0 || n == 2);
		end
		finish_test("frame_start", base);

		base = errors;
		for (int d = 0; d < 3; d++) begin
			write_reg(CMD_PWM_DUTY, 32'(duties[d]));
			high_cycles = 0;
			repeat (4096) begin
				@(posedge w_csi_rx_clk);
				if (pwm_o) begin
					high_cycles++;
				end
			end
			check_value("pwm_o high cycles", 32'(high_cycles), 32'(duties[d]) * 32'd16);
		end
		finish_test("backlight_pwm", base);

		// Credits withheld while the lane FIFOs fill to the brim and past it
		base = errors;
		@(posedge w_csi_rx_clk);
		hold_credits <= 1'b1;
		for (int n = 0; n < PIX_CREDITS + LANE_FIFO_DEPTH; n++) begin
			lanes = lcg_next();
			exp_q.push_back(expect_word(pols[2], lanes));
			send_beat(lanes);
		end
		end_beats();
		wait_words(PIX_CREDITS);
		repeat (50) @(posedge w_csi_rx_clk);
		check_value("words with credits held", 32'(rx_q.size()), 32'(PIX_CREDITS));
		check_value("overflow_o", 32'(overflow_o), 32'd0);
		send_beat(lcg_next());
		end_beats();
		cycles = 0;
		while (!overflow_o && cycles < WAIT_LIMIT) begin
			@(posedge w_csi_rx_clk);
			cycles++;
		end
		assert (overflow_o) else begin
			report_failure("overflow_o stayed low after a write into full lane FIFOs");
		end
		@(posedge w_csi_rx_clk);
		hold_credits <= 1'b0;
		wait_words(PIX_CREDITS + LANE_FIFO_DEPTH);
		repeat (50) @(posedge w_csi_rx_clk);
		check_value("words after credit return", 32'(rx_q.size()),
			32'(PIX_CREDITS + LANE_FIFO_DEPTH));
		while (exp_q.size() > 0) begin
			take_word(exp_q.pop_front(), 1'b0);
		end
		check_value("overflow_o", 32'(overflow_o), 32'd1);
		finish_test("credits_overflow", base);

		$display("Tests run: %0d, errors: %0d", tests_run, errors);
		if (errors == 0) begin
			$display("Test completed successfully");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

//--- hdl/csi_frame_top.sv
module csi_frame_top import csi_pkg::*, ctrl_pkg::*; #(
	parameter int                   LANE_FIFO_DEPTH = 8,
	parameter int                   PIX_CREDITS = 4,
	parameter logic [NUM_LANES-1:0] LANE_POL_RESET = 4'b0011
) (
	input  logic        w_csi_rx_clk,
	input  logic        w_sys_rstn,
	input  lane_bus_t   lanes_i,
	input  logic        vsync_i,
	input  reg_wr_t     reg_wr_i,
	output pixel_beat_t pix_o,
	input  logic        credit_return_i,
	output logic        overflow_o,
	output logic        led_o,
	output logic        pwm_o
);

	// Capture to slices
	lane_entry_t [NUM_LANES-1:0] w_lane_wr;
	logic                        w_lane_wr_en;
	// Slices to merger
	lane_entry_t [NUM_LANES-1:0] w_heads;
	logic [NUM_LANES-1:0]        w_nonempty;
	logic [NUM_LANES-1:0]        w_lane_ovf;
	// Shared pop back to every slice
	logic                        w_pop;
	// Per-lane inversion from the register block
	logic [NUM_LANES-1:0]        w_lane_pol;

	//////////////////////////////////////////////////////////////////////
	// Receive path
	//////////////////////////////////////////////////////////////////////

	lane_capture u_capture (
		.w_csi_rx_clk (w_csi_rx_clk),
		.w_sys_rstn   (w_sys_rstn),
		.lanes_i      (lanes_i),
		.vsync_i      (vsync_i),
		.lane_wr_o    (w_lane_wr),
		.lane_wr_en_o (w_lane_wr_en),
		.led_o        (led_o)
	);

	// One buffer per lane
	for (genvar g = 0; g < NUM_LANES; g++) begin : g_lane
		lane_slice #(
			.LANE_FIFO_DEPTH (LANE_FIFO_DEPTH)
		) u_slice (
			.w_csi_rx_clk (w_csi_rx_clk),
			.w_sys_rstn   (w_sys_rstn),
			.wr_i         (w_lane_wr[g]),
			.wr_en_i      (w_lane_wr_en),
			.pol_i        (w_lane_pol[g]),
			.pop_i        (w_pop),
			.head_o       (w_heads[g]),
			.nonempty_o   (w_nonempty[g]),
			.overflow_o   (w_lane_ovf[g])
		);
	end

	pixel_merger #(
		.PIX_CREDITS (PIX_CREDITS)
	) u_merger (
		.w_csi_rx_clk    (w_csi_rx_clk),
		.w_sys_rstn      (w_sys_rstn),
		.heads_i         (w_heads),
		.nonempty_i      (w_nonempty),
		.lane_ovf_i      (w_lane_ovf),
		.pop_o           (w_pop),
		.credit_return_i (credit_return_i),
		.pix_o           (pix_o),
		.overflow_o      (overflow_o)
	);

	//////////////////////////////////////////////////////////////////////
	// Board control
	//////////////////////////////////////////////////////////////////////

	board_ctrl #(
		.LANE_POL_RESET (LANE_POL_RESET)
	) u_board (
		.w_csi_rx_clk (w_csi_rx_clk),
		.w_sys_rstn   (w_sys_rstn),
		.reg_wr_i     (reg_wr_i),
		.lane_pol_o   (w_lane_pol),
		.pwm_o        (pwm_o)
	);

endmodule

//--- hdl/board_ctrl.sv
module board_ctrl import csi_pkg::*, ctrl_pkg::*; #(
	parameter logic [NUM_LANES-1:0] LANE_POL_RESET = 4'b0011
) (
	input  logic                 w_csi_rx_clk,
	input  logic                 w_sys_rstn,
	input  reg_wr_t              reg_wr_i,
	output logic [NUM_LANES-1:0] lane_pol_o,
	output logic                 pwm_o
);

	logic [NUM_LANES-1:0] r_lane_pol;
	duty_t                r_duty;
	logic [PWM_CNT_W-1:0] rc_pwm;
	logic                 r_pwm;
	logic                 w_ctrl_wr;
	logic [PWM_CNT_W-1:0] w_duty_scaled;

	//////////////////////////////////////////////////////////////////////
	// Register decode
	//////////////////////////////////////////////////////////////////////

	assign w_ctrl_wr = reg_wr_i.valid && (reg_wr_i.index == REG_INDEX_CTRL);

	always_ff @(posedge w_csi_rx_clk or negedge w_sys_rstn) begin
		if (!w_sys_rstn) begin
			r_lane_pol <= LANE_POL_RESET;
			r_duty <= '0;
		end else if (w_ctrl_wr) begin
			if (reg_wr_i.cmd == CMD_LANE_POL) begin
				r_lane_pol <= reg_wr_i.data[NUM_LANES-1:0];
			end
			if (reg_wr_i.cmd == CMD_PWM_DUTY) begin
				r_duty <= reg_wr_i.data[DUTY_W-1:0];
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Backlight PWM
	//////////////////////////////////////////////////////////////////////

	// Duty times 16, zero duty never beats the counter
	assign w_duty_scaled = {r_duty, {(PWM_CNT_W-DUTY_W){1'b0}}};

	always_ff @(posedge w_csi_rx_clk or negedge w_sys_rstn) begin
		if (!w_sys_rstn) begin
			rc_pwm <= '0;
			r_pwm <= 1'b0;
		end else begin
			rc_pwm <= rc_pwm + 1'b1;
			r_pwm <= (w_duty_scaled > rc_pwm);
		end
	end

	assign lane_pol_o = r_lane_pol;
	assign pwm_o = r_pwm;

endmodule

//--- hdl/pixel_merger.sv
module pixel_merger import csi_pkg::*; #(
	parameter int PIX_CREDITS = 4
) (
	input  logic                        w_csi_rx_clk,
	input  logic                        w_sys_rstn,
	input  lane_entry_t [NUM_LANES-1:0] heads_i,
	input  logic [NUM_LANES-1:0]        nonempty_i,
	input  logic [NUM_LANES-1:0]        lane_ovf_i,
	output logic                        pop_o,
	input  logic                        credit_return_i,
	output pixel_beat_t                 pix_o,
	output logic                        overflow_o
);

	// Credit pool plus one spare count so an over-return stays visible
	localparam int CW = $clog2(PIX_CREDITS + 2);

	typedef logic [CW-1:0] cnt_t;

	cnt_t        r_credits;
	logic        r_valid;
	logic        r_sof;
	pixel_word_t r_word;
	logic        r_overflow;
	logic        w_pop;

	//////////////////////////////////////////////////////////////////////
	// Pop decision
	//////////////////////////////////////////////////////////////////////

	// The beat on pix_o still holds a credit this cycle
	// so one must be left over before popping again
	assign w_pop = (&nonempty_i) && (r_credits > cnt_t'(r_valid));
	assign pop_o = w_pop;

	always_ff @(posedge w_csi_rx_clk or negedge w_sys_rstn) begin
		if (!w_sys_rstn) begin
			r_credits <= cnt_t'(PIX_CREDITS);
			r_valid <= 1'b0;
			r_sof <= 1'b0;
			r_overflow <= 1'b0;
		end else begin
			// Spend on output valid and refill on return
			r_credits <= r_credits - cnt_t'(r_valid) + cnt_t'(credit_return_i);
			r_valid <= w_pop;
			// Frame start rides on lane 0
			r_sof <= w_pop & heads_i[0].sof;
			// Sticky until reset
			r_overflow <= r_overflow | (|lane_ovf_i);
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Word packing
	//////////////////////////////////////////////////////////////////////

	// Lane i lands in byte i
	always_ff @(posedge w_csi_rx_clk) begin
		if (w_pop) begin
			for (int i = 0; i < NUM_LANES; i++) begin
				r_word[i*LANE_W +: LANE_W] <= heads_i[i].data;
			end
		end
	end

	assign pix_o = '{word: r_word, sof: r_sof, valid: r_valid};
	assign overflow_o = r_overflow;

	//////////////////////////////////////////////////////////////////////
	// Checks
	//////////////////////////////////////////////////////////////////////

	// Consumer never hands back more than it got
	a_credit_bound: assert property (
		@(posedge w_csi_rx_clk) disable iff (!w_sys_rstn)
		r_credits <= cnt_t'(PIX_CREDITS)
	);

	// A beat on the output always has a credit behind it
	a_valid_has_credit: assert property (
		@(posedge w_csi_rx_clk) disable iff (!w_sys_rstn)
		r_valid |-> (r_credits != '0)
	);

endmodule

//--- hdl/lane_slice.sv
module lane_slice import csi_pkg::*; #(
	parameter int LANE_FIFO_DEPTH = 8
) (
	input  logic        w_csi_rx_clk,
	input  logic        w_sys_rstn,
	input  lane_entry_t wr_i,
	input  logic        wr_en_i,
	input  logic        pol_i,
	input  logic        pop_i,
	output lane_entry_t head_o,
	output logic        nonempty_o,
	output logic        overflow_o
);

	// Pointer carries one wrap bit above the address
	localparam int AW = $clog2(LANE_FIFO_DEPTH);

	typedef logic [AW:0] ptr_t;

	// Entry storage
	lane_entry_t r_mem [0:LANE_FIFO_DEPTH-1];
	ptr_t        r_wr_ptr;
	ptr_t        r_rd_ptr;
	lane_entry_t w_wr_entry;
	logic        w_empty;
	logic        w_full;
	logic        w_push;
	logic        r_overflow;

	//////////////////////////////////////////////////////////////////////
	// Polarity correction
	//////////////////////////////////////////////////////////////////////

	// Swapped P/N on the board shows up as an inverted byte
	assign w_wr_entry = '{data: wr_i.data ^ {LANE_W{pol_i}}, sof: wr_i.sof};

	//////////////////////////////////////////////////////////////////////
	// Lane FIFO
	//////////////////////////////////////////////////////////////////////

	assign w_empty = (r_wr_ptr == r_rd_ptr);
	// Same address, different lap
	assign w_full = (r_wr_ptr[AW] != r_rd_ptr[AW]) &&
		(r_wr_ptr[AW-1:0] == r_rd_ptr[AW-1:0]);
	// Lanes cannot stall, full means the entry is lost
	assign w_push = wr_en_i & ~w_full;

	always_ff @(posedge w_csi_rx_clk or negedge w_sys_rstn) begin
		if (!w_sys_rstn) begin
			r_wr_ptr <= '0;
			r_rd_ptr <= '0;
			r_overflow <= 1'b0;
		end else begin
			if (w_push) begin
				r_wr_ptr <= r_wr_ptr + ptr_t'(1);
			end
			if (pop_i) begin
				r_rd_ptr <= r_rd_ptr + ptr_t'(1);
			end
			// One-cycle pulse per dropped entry
			r_overflow <= wr_en_i & w_full;
		end
	end

	// Storage write
	always_ff @(posedge w_csi_rx_clk) begin
		if (w_push) begin
			r_mem[r_wr_ptr[AW-1:0]] <= w_wr_entry;
		end
	end

	// Head is read straight from storage, first-word fall-through
	assign head_o = r_mem[r_rd_ptr[AW-1:0]];
	assign nonempty_o = ~w_empty;
	assign overflow_o = r_overflow;

	//////////////////////////////////////////////////////////////////////
	// Checks
	//////////////////////////////////////////////////////////////////////

	// Shared pop from the merger must only come when this lane holds data
	a_no_pop_empty: assert property (
		@(posedge w_csi_rx_clk) disable iff (!w_sys_rstn)
		pop_i |-> nonempty_o
	);

endmodule

//--- hdl/lane_capture.sv
module lane_capture import csi_pkg::*; (
	input  logic                        w_csi_rx_clk,
	input  logic                        w_sys_rstn,
	input  lane_bus_t                   lanes_i,
	input  logic                        vsync_i,
	output lane_entry_t [NUM_LANES-1:0] lane_wr_o,
	output logic                        lane_wr_en_o,
	output logic                        led_o
);

	// Registered lane bytes
	lane_byte_t [NUM_LANES-1:0] r_lane_data;
	logic                       r_lane_valid;
	// Frame start tag for the registered beat
	logic                       r_sof;
	// Set by vsync fall, waits for the next valid beat
	logic                       r_sof_armed;
	// Two-stage vsync history, [1] is older
	logic [1:0]                 r_vsync;
	// Frame counter for the LED
	logic [3:0]                 rc_vsync;
	logic                       w_vsync_fall;
	logic                       w_vsync_rise;

	assign w_vsync_fall = (r_vsync == 2'b10);
	assign w_vsync_rise = (r_vsync == 2'b01);

	//////////////////////////////////////////////////////////////////////
	// Control state
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge w_csi_rx_clk or negedge w_sys_rstn) begin
		if (!w_sys_rstn) begin
			r_vsync <= 2'b00;
			r_lane_valid <= 1'b0;
			r_sof <= 1'b0;
			r_sof_armed <= 1'b0;
			rc_vsync <= 4'd0;
		end else begin
			r_vsync <= {r_vsync[0], vsync_i};
			r_lane_valid <= lanes_i.valid;
			// Tag goes on the first valid beat, fall in the same cycle counts too
			r_sof <= lanes_i.valid & (r_sof_armed | w_vsync_fall);
			if (lanes_i.valid) begin
				r_sof_armed <= 1'b0;
			end else if (w_vsync_fall) begin
				r_sof_armed <= 1'b1;
			end
			// Count frames on vsync rise
			if (w_vsync_rise) begin
				rc_vsync <= rc_vsync + 4'd1;
			end
		end
	end

	// Lane bytes, held between beats
	always_ff @(posedge w_csi_rx_clk) begin
		if (lanes_i.valid) begin
			r_lane_data <= lanes_i.data;
		end
	end

	// Fan out one entry per lane, sof on lane 0 only
	always_comb begin
		for (int i = 0; i < NUM_LANES; i++) begin
			lane_wr_o[i].data = r_lane_data[i];
			lane_wr_o[i].sof = (i == 0) ? r_sof : 1'b0;
		end
	end

	assign lane_wr_en_o = r_lane_valid;
	// Toggles every eight frames
	assign led_o = rc_vsync[3];

endmodule

//--- hdl/ctrl_pkg.sv
package ctrl_pkg;

	//////////////////////////////////////////////////////////////////////
	// Register write port
	//////////////////////////////////////////////////////////////////////

	// Index / command / data write, one cycle strobe
	typedef struct packed {
		logic [7:0]  index;
		logic [7:0]  cmd;
		logic [31:0] data;
		logic        valid;
	} reg_wr_t;

	// Only decoded index
	localparam logic [7:0] REG_INDEX_CTRL = 8'h00;

	// Lane polarity, data[3:0], one bit per lane
	localparam logic [7:0] CMD_LANE_POL = 8'h01;
	// Backlight duty, data[7:0]
	localparam logic [7:0] CMD_PWM_DUTY = 8'h03;

	// Backlight PWM
	localparam int PWM_CNT_W = 12;
	localparam int DUTY_W = 8;

	typedef logic [DUTY_W-1:0] duty_t;

endpackage

//--- hdl/csi_pkg.sv
package csi_pkg;

	//////////////////////////////////////////////////////////////////////
	// Lane geometry
	//////////////////////////////////////////////////////////////////////

	// Four HS data lanes, clock lane not counted
	localparam int NUM_LANES = 4;
	// One byte per lane per rx clock
	localparam int LANE_W = 8;
	// Packed pixel word width, RAW8 so one pixel per lane byte
	localparam int PIX_W = NUM_LANES * LANE_W;

	// Single HS lane byte
	typedef logic [LANE_W-1:0] lane_byte_t;

	// Lane bytes as they arrive, already aligned
	// Lane 0 sits in the lowest byte
	typedef struct packed {
		lane_byte_t [NUM_LANES-1:0] data;
		logic                       valid;
	} lane_bus_t;

	// Lane FIFO payload
	// Start of frame only ever set on lane 0
	typedef struct packed {
		lane_byte_t data;
		logic       sof;
	} lane_entry_t;

	// Four RAW8 pixels, lane 0 in bits 7:0
	typedef logic [PIX_W-1:0] pixel_word_t;

	// Merged output beat
	typedef struct packed {
		pixel_word_t word;
		logic        sof;
		logic        valid;
	} pixel_beat_t;

endpackage
